/* hw/core_demux_pkg.sv */
`default_nettype none

package core_demux_pkg;

  // Bus widths
  localparam int unsigned ADDR_W       = 32;
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned BE_W         = DATA_W / 8;
  localparam int unsigned NUM_TGT      = 4;
  localparam int unsigned CLUSTER_ID_W = 6;

  // Target index, also the bit position in the tgt_* vectors
  typedef enum logic [1:0] {
    TGT_TCDM = 2'd0,
    TGT_L2   = 2'd1,
    TGT_EU   = 2'd2,
    TGT_DMA  = 2'd3
  } tgt_e;

  // Cluster address map
  localparam logic [ADDR_W-1:0] ALIAS_BASE     = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] CLUSTER_BASE   = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] CLUSTER_STRIDE = 32'h0040_0000;
  localparam logic [ADDR_W-1:0] TCDM_SIZE      = 32'h0010_0000;

  // Peripheral windows, offsets inside the cluster window
  localparam logic [ADDR_W-1:0] EU_OFFS  = 32'h0020_0800;
  localparam logic [ADDR_W-1:0] EU_SIZE  = 32'h0000_0400;
  localparam logic [ADDR_W-1:0] DMA_OFFS = 32'h0020_1C00;
  localparam logic [ADDR_W-1:0] DMA_SIZE = 32'h0000_0400;

  // In-flight limit, all to the same target
  localparam int unsigned MAX_OUTST = 2;
  localparam int unsigned OUTST_W   = 2;

  // Perf event outputs
  localparam int unsigned NUM_PERF       = 4;
  localparam int unsigned PERF_L2_LD     = 0;
  localparam int unsigned PERF_L2_ST     = 1;
  localparam int unsigned PERF_L2_LD_CYC = 2;
  localparam int unsigned PERF_L2_ST_CYC = 3;

endpackage

`default_nettype wire

/* hw/addr_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

module addr_decoder (
  input  logic [core_demux_pkg::ADDR_W-1:0]       core_addr_i,
  input  logic [core_demux_pkg::CLUSTER_ID_W-1:0] cluster_id_i,
  output core_demux_pkg::tgt_e                    tgt_o,
  output logic [core_demux_pkg::ADDR_W-1:0]       addr_o
);

  import core_demux_pkg::*;

  logic [ADDR_W-1:0] own_base;
  logic [ADDR_W-1:0] alias_offs;
  logic              in_alias;
  logic [ADDR_W-1:0] own_offs;
  logic              in_own;

  // Start of this cluster's own window
  assign own_base = CLUSTER_BASE + ADDR_W'(cluster_id_i) * CLUSTER_STRIDE;

  // Wraps to a large value below the alias base, so one compare covers both bounds
  assign alias_offs = core_addr_i - ALIAS_BASE;
  assign in_alias   = alias_offs < CLUSTER_STRIDE;

  // Alias rebase onto the own window
  always_comb begin
    if (in_alias) begin
      addr_o = own_base + alias_offs;
    end else begin
      addr_o = core_addr_i;
    end
  end

  assign own_offs = addr_o - own_base;
  assign in_own   = own_offs < CLUSTER_STRIDE;

  // Region compares on the offset inside the own window
  always_comb begin
    tgt_o = TGT_L2; // Other clusters and everything outside
    if (in_own) begin
      if (own_offs < TCDM_SIZE) begin
        tgt_o = TGT_TCDM;
      end else if ((own_offs - EU_OFFS) < EU_SIZE) begin
        tgt_o = TGT_EU;
      end else if ((own_offs - DMA_OFFS) < DMA_SIZE) begin
        tgt_o = TGT_DMA;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/demux_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module demux_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 core_req_i,
  input  core_demux_pkg::tgt_e dec_tgt_i,
  input  logic                 fwd_gnt_i,
  input  logic                 rvalid_i,
  output logic                 req_allow_o,
  output core_demux_pkg::tgt_e act_tgt_o
);

  import core_demux_pkg::*;

  logic [OUTST_W-1:0] cnt_q;
  logic [OUTST_W-1:0] cnt_d;
  tgt_e               act_tgt_q;
  tgt_e               act_tgt_d;
  logic               idle;
  logic               same_tgt;
  logic               slot_free;

  assign idle     = cnt_q == '0;
  assign same_tgt = dec_tgt_i == act_tgt_q;

  // A response in this cycle frees a slot for the new grant
  assign slot_free = (cnt_q < OUTST_W'(MAX_OUTST)) || rvalid_i;

  // Switching target only once everything has drained, so responses stay in order
  always_comb begin
    req_allow_o = 1'b0;
    if (core_req_i) begin
      if (idle) begin
        req_allow_o = 1'b1;
      end else if (same_tgt && slot_free) begin
        req_allow_o = 1'b1;
      end
    end
  end

  // In-flight count
  always_comb begin
    case ({fwd_gnt_i, rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q; // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Active target follows the first grant out of idle
  always_comb begin
    act_tgt_d = act_tgt_q;
    if (fwd_gnt_i && idle) begin
      act_tgt_d = dec_tgt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      act_tgt_q <= TGT_TCDM;
    end else begin
      act_tgt_q <= act_tgt_d;
    end
  end

  assign act_tgt_o = act_tgt_q;

endmodule

`default_nettype wire

/* hw/port_router.sv */
`default_nettype none
`timescale 1ns/100ps

module port_router (
  input  logic                                                    core_req_i,
  input  core_demux_pkg::tgt_e                                    dec_tgt_i,
  input  logic [core_demux_pkg::ADDR_W-1:0]                       dec_addr_i,
  input  logic                                                    core_we_i,
  input  logic [core_demux_pkg::DATA_W-1:0]                       core_wdata_i,
  input  logic [core_demux_pkg::BE_W-1:0]                         core_be_i,
  input  logic                                                    req_allow_i,
  input  core_demux_pkg::tgt_e                                    act_tgt_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_gnt_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_rvalid_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0][core_demux_pkg::DATA_W-1:0] tgt_rdata_i,
  output logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0]                       tgt_addr_o,
  output logic                                                    tgt_we_o,
  output logic [core_demux_pkg::DATA_W-1:0]                       tgt_wdata_o,
  output logic [core_demux_pkg::BE_W-1:0]                         tgt_be_o,
  output logic                                                    fwd_gnt_o,
  output logic                                                    core_rvalid_o,
  output logic [core_demux_pkg::DATA_W-1:0]                       core_rdata_o
);

  import core_demux_pkg::*;

  logic req_go;

  assign req_go = core_req_i && req_allow_i;

  // One request line at most
  always_comb begin
    tgt_req_o = '0;
    if (req_go) begin
      tgt_req_o[dec_tgt_i] = 1'b1;
    end
  end

  // Shared request fields, only the addressed target samples them
  assign tgt_addr_o  = dec_addr_i;
  assign tgt_we_o    = core_we_i;
  assign tgt_wdata_o = core_wdata_i;
  assign tgt_be_o    = core_be_i;

  assign fwd_gnt_o = req_go && tgt_gnt_i[dec_tgt_i];

  // Responses come back from the target holding the in-flight requests
  assign core_rvalid_o = tgt_rvalid_i[act_tgt_i];
  assign core_rdata_o  = tgt_rdata_i[act_tgt_i];

endmodule

`default_nettype wire

/* hw/perf_tracker.sv */
`default_nettype none
`timescale 1ns/100ps

module perf_tracker (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                core_req_i,
  input  logic                                core_we_i,
  input  core_demux_pkg::tgt_e                dec_tgt_i,
  input  logic                                fwd_gnt_i,
  input  logic                                core_rvalid_i,
  input  core_demux_pkg::tgt_e                act_tgt_i,
  output logic [core_demux_pkg::NUM_PERF-1:0] ext_perf_o
);

  import core_demux_pkg::*;

  logic [MAX_OUTST-1:0] st_q; // Store flag per in-flight L2 access, slot 0 oldest
  logic [MAX_OUTST-1:0] st_d;
  logic [OUTST_W-1:0]   l2_cnt_q;
  logic [OUTST_W-1:0]   l2_cnt_d;
  logic [OUTST_W-1:0]   cnt_pop;
  logic                 l2_req;
  logic                 push;
  logic                 pop;
  logic                 ld_pend;
  logic                 st_pend;
  logic [NUM_PERF-1:0]  perf_d;

  assign l2_req = core_req_i && (dec_tgt_i == TGT_L2);
  assign push   = l2_req && fwd_gnt_i;
  assign pop    = core_rvalid_i && (act_tgt_i == TGT_L2);

  always_comb begin
    ld_pend = 1'b0;
    st_pend = 1'b0;
    for (int i = 0; i < MAX_OUTST; i++) begin
      if (OUTST_W'(i) < l2_cnt_q) begin
        ld_pend = ld_pend | ~st_q[i];
        st_pend = st_pend | st_q[i];
      end
    end
    // Responses are in order, so pop shifts and push appends at the tail
    st_d    = pop ? (st_q >> 1) : st_q;
    cnt_pop = l2_cnt_q - OUTST_W'(pop);
    for (int i = 0; i < MAX_OUTST; i++) begin
      if (push && (cnt_pop == OUTST_W'(i))) begin
        st_d[i] = core_we_i;
      end
    end
    l2_cnt_d = cnt_pop + OUTST_W'(push);
  end

  always_comb begin
    perf_d                 = '0;
    perf_d[PERF_L2_LD]     = push && !core_we_i;
    perf_d[PERF_L2_ST]     = push && core_we_i;
    perf_d[PERF_L2_LD_CYC] = (l2_req && !core_we_i && !fwd_gnt_i) || ld_pend;
    perf_d[PERF_L2_ST_CYC] = (l2_req && core_we_i && !fwd_gnt_i) || st_pend;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      st_q       <= '0;
      l2_cnt_q   <= '0;
      ext_perf_o <= '0;
    end else begin
      st_q       <= st_d;
      l2_cnt_q   <= l2_cnt_d;
      ext_perf_o <= perf_d; // One cycle after the event
    end
  end

endmodule

`default_nettype wire

/* hw/core_demux_top.sv */
`default_nettype none
`timescale 1ns/100ps

module core_demux_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  logic [core_demux_pkg::CLUSTER_ID_W-1:0]                 cluster_id_i,
  // Core side
  input  logic                                                    core_req_i,
  input  logic [core_demux_pkg::ADDR_W-1:0]                       core_addr_i,
  input  logic                                                    core_we_i,
  input  logic [core_demux_pkg::DATA_W-1:0]                       core_wdata_i,
  input  logic [core_demux_pkg::BE_W-1:0]                         core_be_i,
  output logic                                                    core_gnt_o,
  output logic                                                    core_rvalid_o,
  output logic [core_demux_pkg::DATA_W-1:0]                       core_rdata_o,
  // Target side
  output logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_req_o,
  output logic [core_demux_pkg::ADDR_W-1:0]                       tgt_addr_o,
  output logic                                                    tgt_we_o,
  output logic [core_demux_pkg::DATA_W-1:0]                       tgt_wdata_o,
  output logic [core_demux_pkg::BE_W-1:0]                         tgt_be_o,
  input  logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_gnt_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0]                      tgt_rvalid_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0][core_demux_pkg::DATA_W-1:0] tgt_rdata_i,
  output logic [core_demux_pkg::NUM_PERF-1:0]                     ext_perf_o
);

  import core_demux_pkg::*;

  tgt_e              dec_tgt;
  logic [ADDR_W-1:0] dec_addr;
  logic              req_allow;
  tgt_e              act_tgt;
  logic              fwd_gnt;

  assign core_gnt_o = fwd_gnt;

  addr_decoder addr_decoder_inst (
    .core_addr_i  (core_addr_i),
    .cluster_id_i (cluster_id_i),
    .tgt_o        (dec_tgt),
    .addr_o       (dec_addr)
  );

  demux_ctrl demux_ctrl_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .core_req_i  (core_req_i),
    .dec_tgt_i   (dec_tgt),
    .fwd_gnt_i   (fwd_gnt),
    .rvalid_i    (core_rvalid_o),
    .req_allow_o (req_allow),
    .act_tgt_o   (act_tgt)
  );

  port_router port_router_inst (
    .core_req_i    (core_req_i),
    .dec_tgt_i     (dec_tgt),
    .dec_addr_i    (dec_addr),
    .core_we_i     (core_we_i),
    .core_wdata_i  (core_wdata_i),
    .core_be_i     (core_be_i),
    .req_allow_i   (req_allow),
    .act_tgt_i     (act_tgt),
    .tgt_gnt_i     (tgt_gnt_i),
    .tgt_rvalid_i  (tgt_rvalid_i),
    .tgt_rdata_i   (tgt_rdata_i),
    .tgt_req_o     (tgt_req_o),
    .tgt_addr_o    (tgt_addr_o),
    .tgt_we_o      (tgt_we_o),
    .tgt_wdata_o   (tgt_wdata_o),
    .tgt_be_o      (tgt_be_o),
    .fwd_gnt_o     (fwd_gnt),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o)
  );

  perf_tracker perf_tracker_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .core_req_i    (core_req_i),
    .core_we_i     (core_we_i),
    .dec_tgt_i     (dec_tgt),
    .fwd_gnt_i     (fwd_gnt),
    .core_rvalid_i (core_rvalid_o),
    .act_tgt_i     (act_tgt),
    .ext_perf_o    (ext_perf_o)
  );

endmodule

`default_nettype wire

/* bench/target_model.sv */
`default_nettype none
`timescale 1ns/100ps

module target_model #(
  parameter int unsigned LATENCY = 1
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0]        mem [64];
  logic               stall_q;
  logic [LATENCY-1:0] vld_q;
  logic [31:0]        dat_q [LATENCY];

  assign gnt_o    = req_i && !stall_q;
  assign rvalid_o = vld_q[LATENCY-1];
  assign rdata_o  = dat_q[LATENCY-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stall_q <= 1'b0;
      vld_q   <= '0;
      for (int i = 0; i < 64; i++) begin
        mem[i] <= 32'hc0de_0000 + 32'(i);
      end
    end else begin
      stall_q <= ($urandom % 3) == 0; // Grant held low about a third of the time
      for (int i = LATENCY - 1; i > 0; i--) begin
        vld_q[i] <= vld_q[i-1];
        dat_q[i] <= dat_q[i-1];
      end
      vld_q[0] <= gnt_o;
      dat_q[0] <= mem[addr_i[7:2]];
      if (gnt_o && we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i[7:2]][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/core_demux_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module core_demux_chk (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [core_demux_pkg::NUM_TGT-1:0] tgt_req_o,
  input  logic                               core_gnt_o,
  input  logic                               core_rvalid_o
);

  import core_demux_pkg::*;

  logic [OUTST_W-1:0] cnt_q;
  logic [NUM_TGT-1:0] last_q; // Request line of the latest grant

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      last_q <= '0;
    end else begin
      cnt_q <= cnt_q + OUTST_W'(core_gnt_o) - OUTST_W'(core_rvalid_o);
      if (core_gnt_o) begin
        last_q <= tgt_req_o;
      end
    end
  end

  a_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(tgt_req_o)) else $error("more than one target request line high");

  a_rvalid_outst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_rvalid_o |-> cnt_q != '0) else $error("response with nothing in flight");

  a_same_tgt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (core_gnt_o && cnt_q != '0) |-> tgt_req_o == last_q)
    else $error("grant to another target before drain");

endmodule

`default_nettype wire

/* bench/tb_core_demux.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_core_demux;

  import core_demux_pkg::*;

  localparam int TIMEOUT = 4000; // About 60 accesses, each far below 60 cycles

  logic                          clk_i;
  logic                          rst_n_i;
  logic [CLUSTER_ID_W-1:0]       cluster_id_i;
  logic                          core_req_i;
  logic [ADDR_W-1:0]             core_addr_i;
  logic                          core_we_i;
  logic [DATA_W-1:0]             core_wdata_i;
  logic [BE_W-1:0]               core_be_i;
  logic                          core_gnt_o;
  logic                          core_rvalid_o;
  logic [DATA_W-1:0]             core_rdata_o;
  logic [NUM_TGT-1:0]            tgt_req_o;
  logic [ADDR_W-1:0]             tgt_addr_o;
  logic                          tgt_we_o;
  logic [DATA_W-1:0]             tgt_wdata_o;
  logic [BE_W-1:0]               tgt_be_o;
  logic [NUM_TGT-1:0]            tgt_gnt_i;
  logic [NUM_TGT-1:0]            tgt_rvalid_i;
  logic [NUM_TGT-1:0][DATA_W-1:0] tgt_rdata_i;
  logic [NUM_PERF-1:0]           ext_perf_o;

  int                cycles;
  int                gnt_total;
  int                rv_total;
  int                perf_cnt [NUM_PERF];
  logic [DATA_W-1:0] rsp_q [$];
  logic [NUM_TGT-1:0] gnt_req;  // Captured at the grant edge
  logic [ADDR_W-1:0]  gnt_addr;

  core_demux_top core_demux_top_inst (.*);

  bind core_demux_top core_demux_chk core_demux_chk_inst (.*);

  for (genvar g = 0; g < NUM_TGT; g++) begin : gen_tgt
    target_model #(.LATENCY(g == 0 ? 1 : (g == 1 ? 3 : 2))) target_model_inst (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (tgt_req_o[g]),
      .addr_i   (tgt_addr_o),
      .we_i     (tgt_we_o),
      .wdata_i  (tgt_wdata_o),
      .be_i     (tgt_be_o),
      .gnt_o    (tgt_gnt_i[g]),
      .rvalid_o (tgt_rvalid_i[g]),
      .rdata_o  (tgt_rdata_i[g])
    );
  end

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the DUT stopped answering");
      $display("Test FAILED");
      $fatal(1, "run aborted");
    end
  end

  // Grant, response and perf pulse monitor
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      gnt_total += int'(core_gnt_o);
      if (core_rvalid_o) begin
        rv_total++;
        rsp_q.push_back(core_rdata_o);
      end
      for (int i = 0; i < NUM_PERF; i++) begin
        perf_cnt[i] += int'(ext_perf_o[i]);
      end
    end
  end

  function automatic logic [ADDR_W-1:0] map_addr(input logic [ADDR_W-1:0] a,
                                                 input logic [CLUSTER_ID_W-1:0] cid);
    if (a >= ALIAS_BASE && a < ALIAS_BASE + CLUSTER_STRIDE) begin
      return a - ALIAS_BASE + CLUSTER_BASE + (32'(cid) << 22);
    end
    return a;
  endfunction

  function automatic tgt_e map_tgt(input logic [ADDR_W-1:0] a,
                                   input logic [CLUSTER_ID_W-1:0] cid);
    logic [ADDR_W-1:0] own;
    logic [ADDR_W-1:0] r;
    own = CLUSTER_BASE + (32'(cid) << 22);
    r   = map_addr(a, cid);
    if (r < own || r >= own + CLUSTER_STRIDE) return TGT_L2;
    if (r < own + TCDM_SIZE) return TGT_TCDM;
    if (r >= own + EU_OFFS && r < own + EU_OFFS + EU_SIZE) return TGT_EU;
    if (r >= own + DMA_OFFS && r < own + DMA_OFFS + DMA_SIZE) return TGT_DMA;
    return TGT_L2; // Gaps inside the own window
  endfunction

  function automatic tgt_e line_to_tgt(input logic [NUM_TGT-1:0] lines);
    case (lines)
      4'b0010: return TGT_L2;
      4'b0100: return TGT_EU;
      4'b1000: return TGT_DMA;
      default: return TGT_TCDM;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_tgt(input string name, input tgt_e got, input tgt_e exp);
    if (got != exp) report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) report_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // Holds the request until it is granted
  task automatic issue(input logic [ADDR_W-1:0] a, input logic we, input logic [DATA_W-1:0] d);
    @(negedge clk_i);
    core_req_i   = 1'b1;
    core_addr_i  = a;
    core_we_i    = we;
    core_wdata_i = d;
    do @(posedge clk_i); while (!core_gnt_o);
    gnt_req  = tgt_req_o;
    gnt_addr = tgt_addr_o;
  endtask

  task automatic drain();
    @(negedge clk_i);
    core_req_i = 1'b0;
    while (rv_total != gnt_total) @(negedge clk_i);
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_word("tgt_req_o", 32'(tgt_req_o), '0);
    check_word("core_rvalid_o", 32'(core_rvalid_o), '0);
    check_word("ext_perf_o", 32'(ext_perf_o), '0);
  endtask

  task automatic test_routing();
    logic [ADDR_W-1:0] addrs [7];
    addrs = '{32'h1080_0020, 32'h10A0_0804, 32'h10A0_1C08, 32'h1140_0000,
              32'h2000_0000, 32'h1000_0800, 32'h1095_0000};
    cluster_id_i = 6'd2;
    foreach (addrs[i]) begin
      issue(addrs[i], 1'b0, '0);
      check_tgt("tgt_req_o", line_to_tgt(gnt_req), map_tgt(addrs[i], 6'd2));
      check_count("tgt_req_o ones", $countones(gnt_req), 1);
      check_word("tgt_addr_o", gnt_addr, map_addr(addrs[i], 6'd2));
    end
    drain();
  endtask

  task automatic test_round_trip();
    logic [ADDR_W-1:0] addrs [4];
    logic [DATA_W-1:0] d;
    addrs = '{32'h1000_0010, 32'h8000_0020, 32'h1020_0804, 32'h1020_1C08};
    cluster_id_i = 6'd0;
    foreach (addrs[i]) begin
      d = $urandom;
      issue(addrs[i], 1'b1, d);
      issue(addrs[i], 1'b0, '0);
      drain();
      check_word("core_rdata_o", rsp_q[$], d);
      core_be_i = 4'h3; // Low half only
      issue(addrs[i], 1'b1, ~d);
      drain();
      core_be_i = 4'hf;
      issue(addrs[i], 1'b0, '0);
      drain();
      check_word("core_rdata_o", rsp_q[$], {d[31:16], ~d[15:0]});
    end
  endtask

  task automatic test_alias();
    logic [DATA_W-1:0] d;
    logic [ADDR_W-1:0] wr_addr;
    d = $urandom;
    cluster_id_i = 6'd3;
    issue(32'h1000_0040, 1'b1, d);
    check_tgt("tgt_req_o", line_to_tgt(gnt_req), TGT_TCDM);
    wr_addr = gnt_addr;
    issue(32'h10C0_0040, 1'b0, '0);
    check_tgt("tgt_req_o", line_to_tgt(gnt_req), TGT_TCDM);
    check_word("tgt_addr_o", gnt_addr, wr_addr);
    check_word("tgt_addr_o", wr_addr, map_addr(32'h1000_0040, 6'd3));
    drain();
    check_word("core_rdata_o", rsp_q[$], d);
  endtask

  task automatic test_ordering();
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] d;
    int gnt_start;
    cluster_id_i = 6'd0;
    for (int i = 0; i < 8; i++) begin
      d = $urandom;
      exp_q.push_back(d);
      issue((i % 2 == 0 ? 32'h1000_0080 : 32'h9000_0080) + 32'(i / 2 * 4), 1'b1, d);
    end
    drain();
    rsp_q.delete();
    gnt_start = gnt_total;
    for (int i = 0; i < 8; i++) begin
      issue((i % 2 == 0 ? 32'h1000_0080 : 32'h9000_0080) + 32'(i / 2 * 4), 1'b0, '0);
    end
    drain();
    check_count("core_gnt_o pulses", gnt_total - gnt_start, 8);
    check_count("core_rvalid_o pulses", rsp_q.size(), 8);
    foreach (exp_q[i]) check_word("core_rdata_o", rsp_q[i], exp_q[i]);
  endtask

  task automatic test_perf();
    repeat (2) @(negedge clk_i); // Registered pulses of the last L2 read still in flight
    foreach (perf_cnt[i]) perf_cnt[i] = 0;
    issue(32'h1000_0000, 1'b0, '0);
    issue(32'h1000_0004, 1'b1, 32'h1);
    drain();
    repeat (2) @(negedge clk_i);
    foreach (perf_cnt[i]) check_count("ext_perf_o", perf_cnt[i], 0);
    foreach (perf_cnt[i]) perf_cnt[i] = 0;
    issue(32'h8000_0000, 1'b0, '0);
    issue(32'h8000_0004, 1'b1, 32'h5);
    issue(32'h8000_0008, 1'b0, '0);
    issue(32'h1000_0008, 1'b0, '0);
    issue(32'h8000_000c, 1'b1, 32'h6);
    issue(32'h8000_0010, 1'b0, '0);
    drain();
    repeat (2) @(negedge clk_i);
    check_count("ext_perf_o[PERF_L2_LD]", perf_cnt[PERF_L2_LD], 3);
    check_count("ext_perf_o[PERF_L2_ST]", perf_cnt[PERF_L2_ST], 2);
    if (perf_cnt[PERF_L2_LD_CYC] == 0 || perf_cnt[PERF_L2_ST_CYC] == 0) begin
      report_error("L2 wait-cycle pulses missing after L2 accesses");
    end
  endtask

  initial begin
    void'($urandom(32'hb3ea));
    rst_n_i      = 1'b0;
    cluster_id_i = '0;
    core_req_i   = 1'b0;
    core_addr_i  = '0;
    core_we_i    = 1'b0;
    core_wdata_i = '0;
    core_be_i    = 4'hf;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset();
    test_routing();
    test_round_trip();
    test_alias();
    test_ordering();
    test_perf();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/core_demux_pkg.sv
hw/addr_decoder.sv
hw/demux_ctrl.sv
hw/port_router.sv
hw/perf_tracker.sv
hw/core_demux_top.sv
bench/target_model.sv
bench/core_demux_chk.sv
bench/tb_core_demux.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, result taken from sim.log
verilator --binary --timing --assert --top-module tb_core_demux -f src.f -o tb_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || grep -q "Test OK" sim.log
